// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0 --Wno-fatal
TOP      = cpu_tb
FILELIST = src.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/cpu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions (
	input logic        clock,
	input logic        rst_n,
	input logic        wb_cyc,
	input logic        wb_stb,
	input logic        wb_we,
	input logic [31:0] wb_adr,
	input logic [31:0] wb_dat_w,
	input logic [3:0]  wb_sel,
	input logic        wb_ack
);

	// Bus stays idle through reset.
	idle_in_reset: assert property (@(posedge clock) !rst_n |-> !wb_cyc && !wb_stb)
		else $error("Bus active during reset.");

	hold_until_ack: assert property (@(posedge clock) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_sel)
		                      && $stable(wb_dat_w))
		else $error("Request changed before ack.");

	stb_needs_cyc: assert property (@(posedge clock) disable iff (!rst_n) wb_stb |-> wb_cyc)
		else $error("Strobe without cycle.");

endmodule

`default_nettype wire

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	import core_pkg::*;

	localparam logic [31:0] RESET_PC  = 32'h3000_0000;
	localparam logic [31:0] DATA_BASE = 32'h1000_0000;
	localparam logic [31:0] HALT_ADDR = 32'h2000_0000;
	localparam int N_RAND   = 200;
	localparam int PROG_LEN = N_RAND + 8;
	localparam int TIMEOUT_CYCLES = N_RAND * 16 * 2 + 10;

	localparam int K_OP    = 0;
	localparam int K_IMM   = 1;
	localparam int K_LUI   = 2;
	localparam int K_AUIPC = 3;
	localparam int K_BR    = 4;
	localparam int K_JAL   = 5;
	localparam int K_JALR  = 6;
	localparam int K_LOAD  = 7;
	localparam int K_STORE = 8;

	logic        clock;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [3:0]  wb_sel;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	logic [31:0] lfsr_state = 32'h84d0d3b3;
	int          errors = 0;
	logic        halted = 1'b0;
	logic        pending = 1'b0;
	logic [1:0]  delay = 2'd0;

	// One program entry per instruction.
	int          prog_kind [PROG_LEN];
	logic [2:0]  prog_f3   [PROG_LEN];
	logic        prog_alt  [PROG_LEN];
	logic [3:0]  prog_rd   [PROG_LEN];
	logic [3:0]  prog_rs1  [PROG_LEN];
	logic [3:0]  prog_rs2  [PROG_LEN];
	logic [31:0] prog_imm  [PROG_LEN];

	logic [31:0] mem     [logic [31:0]];
	logic [31:0] ref_mem [logic [31:0]];
	logic [31:0] model_regs [16];
	logic        model_clint [16]; // Value came from the timer.

	logic [31:0] exp_reads [$];
	logic [31:0] exp_st_adr [$];
	logic [3:0]  exp_st_sel [$];
	logic [31:0] exp_st_dat [$];
	logic        exp_st_clint [$];
	logic [31:0] clint_vals [$];

	cpu_top #(.RESET_PC(RESET_PC), .NUM_REGS(16)) u_cpu_top (
		.clock(clock), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	bind cpu_top cpu_assertions u_cpu_assertions (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return a ^ 32'h6b3c_1e5d;
	endfunction

	function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [3:0] sel,
	                                           input logic [31:0] d);
		logic [31:0] w;
		w = old;
		for (int b = 0; b < 4; b++)
			if (sel[b])
				w[8*b +: 8] = d[8*b +: 8];
		return w;
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f, input logic alt,
	                                        input logic [31:0] a, input logic [31:0] b);
		case (f)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic taken_ref(input logic [2:0] f, input logic [31:0] a,
	                                   input logic [31:0] b);
		case (f)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] encode(input int i);
		logic [31:0] im;
		logic [4:0]  rd;
		logic [4:0]  r1;
		logic [4:0]  r2;
		im = prog_imm[i];
		rd = {1'b0, prog_rd[i]};
		r1 = {1'b0, prog_rs1[i]};
		r2 = {1'b0, prog_rs2[i]};
		case (prog_kind[i])
			K_OP:    return {prog_alt[i] ? 7'h20 : 7'h00, r2, r1, prog_f3[i], rd, 7'b0110011};
			K_IMM:   return {im[11:0], r1, prog_f3[i], rd, 7'b0010011};
			K_LOAD:  return {im[11:0], r1, prog_f3[i], rd, 7'b0000011};
			K_JALR:  return {im[11:0], r1, 3'b000, rd, 7'b1100111};
			K_STORE: return {im[11:5], r2, r1, prog_f3[i], im[4:0], 7'b0100011};
			K_BR: return {im[12], im[10:5], r2, r1, prog_f3[i], im[4:1], im[11], 7'b1100011};
			K_LUI:   return {im[31:12], rd, 7'b0110111};
			K_AUIPC: return {im[31:12], rd, 7'b0010111};
			default: return {im[20], im[10:1], im[11], im[19:12], rd, 7'b1101111};
		endcase
	endfunction

	task automatic put(input int i, input int kind, input logic [2:0] f3, input logic alt,
	                   input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2,
	                   input logic [31:0] imm);
		prog_kind[i] = kind;
		prog_f3[i]   = f3;
		prog_alt[i]  = alt;
		prog_rd[i]   = rd;
		prog_rs1[i]  = rs1;
		prog_rs2[i]  = rs2;
		prog_imm[i]  = imm;
	endtask

	function automatic logic [3:0] pick_rd();
		logic [3:0] r;
		r = 4'(rand_bits(4));
		return (r == 4'd15) ? 4'd0 : r; // x15 holds the data base.
	endfunction

	task automatic build_program();
		int          i;
		int          k;
		int          choice;
		logic [2:0]  f;
		logic [31:0] im;
		logic [3:0]  ld_rd;
		logic [2:0]  br_f3 [6];
		logic [2:0]  ld_f3 [5];
		br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		put(0, K_LUI, 0, 0, 15, 0, 0, DATA_BASE);
		i = 1;
		while (i < N_RAND) begin
			choice = int'(rand_bits(4));
			if (choice == 13 && i + 1 >= N_RAND)
				choice = 14;
			if (choice < 4) begin
				f = 3'(rand_bits(3));
				put(i, K_OP, f, (f == 3'd0 || f == 3'd5) && rand_bits(1) == 1, pick_rd(),
				    4'(rand_bits(4)), 4'(rand_bits(4)), 0);
			end else if (choice < 8) begin
				f = 3'(rand_bits(3));
				if (f == 3'd1 || f == 3'd5) begin
					k = int'(rand_bits(1));
					im = {21'b0, f == 3'd5 && k == 1, 5'b0, 5'(rand_bits(5))};
					put(i, K_IMM, f, f == 3'd5 && k == 1, pick_rd(), 4'(rand_bits(4)), 0, im);
				end else begin
					im = rand_bits(12);
					put(i, K_IMM, f, 0, pick_rd(), 4'(rand_bits(4)), 0,
					    {{20{im[11]}}, im[11:0]});
				end
			end else if (choice < 10) begin
				put(i, choice == 8 ? K_LUI : K_AUIPC, 0, 0, pick_rd(), 0, 0, rand_bits(20) << 12);
			end else if (choice < 13) begin
				k = 2 + int'(rand_bits(2));
				if (i + k > N_RAND)
					k = N_RAND - i;
				if (choice == 12)
					put(i, K_JAL, 0, 0, pick_rd(), 0, 0, 32'(4 * k));
				else
					put(i, K_BR, br_f3[int'(rand_bits(3)) % 6], 0, 0, 4'(rand_bits(4)),
					    4'(rand_bits(4)), 32'(4 * k));
			end else if (choice == 13) begin
				k = 1 + int'(rand_bits(2));
				if (i + 1 + k > N_RAND)
					k = N_RAND - i - 1;
				put(i, K_AUIPC, 0, 0, 14, 0, 0, 0);
				i++;
				put(i, K_JALR, 0, 0, pick_rd(), 14, 0, 32'(4 * (k + 1)));
			end else begin
				f = (choice == 14) ? ld_f3[int'(rand_bits(3)) % 5] : 3'(rand_bits(2) % 3);
				case (f[1:0])
					2'd0: im = rand_bits(8);
					2'd1: im = rand_bits(7) << 1;
					default: im = rand_bits(6) << 2;
				endcase
				if (choice == 14) begin
					ld_rd = 4'd1 + 4'(rand_bits(4) % 14);
					put(i, K_LOAD, f, 0, ld_rd, 15, 0, im);
					if (i + 1 < N_RAND) begin
						i++;
						// Word store that shows the loaded value.
						put(i, K_STORE, 3'd2, 0, 0, 15, ld_rd, rand_bits(6) << 2);
					end
				end else begin
					put(i, K_STORE, f, 0, 0, 15, 4'(rand_bits(4)), im);
				end
			end
			i++;
		end
		// Two timer reads are stored out before the halt store.
		put(N_RAND,     K_LUI,   0, 0, 3,  0,  0, CLINT_BASE);
		put(N_RAND + 1, K_LOAD,  2, 0, 1,  3,  0, 0);
		put(N_RAND + 2, K_STORE, 2, 0, 0,  15, 1, 256);
		put(N_RAND + 3, K_LOAD,  2, 0, 2,  3,  0, 0);
		put(N_RAND + 4, K_STORE, 2, 0, 0,  15, 2, 260);
		put(N_RAND + 5, K_LUI,   0, 0, 13, 0,  0, HALT_ADDR);
		put(N_RAND + 6, K_STORE, 2, 0, 0,  13, 0, 0);
		put(N_RAND + 7, K_JAL,   0, 0, 0,  0,  0, 0);
		for (int n = 0; n < PROG_LEN; n++)
			mem[RESET_PC + 32'(4 * n)] = encode(n);
		for (int n = 0; n < 64; n++) begin
			im = rand_bits(32);
			mem[DATA_BASE + 32'(4 * n)] = im;
			ref_mem[DATA_BASE + 32'(4 * n)] = im;
		end
	endtask

	task automatic write_reg(input logic [3:0] r, input logic [31:0] v, input logic c);
		if (r != 4'd0) begin
			model_regs[r]  = v;
			model_clint[r] = c;
		end
	endtask

	function automatic logic [31:0] read_ref(input logic [31:0] a);
		return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
	endfunction

	task automatic run_model();
		logic [31:0] pc;
		logic [31:0] nxt;
		logic [31:0] a;
		logic [31:0] v;
		logic [31:0] w;
		logic [31:0] im;
		logic [3:0]  sl;
		logic [2:0]  f;
		logic [3:0]  rd;
		logic [31:0] s1;
		logic [31:0] s2;
		logic        stop;
		int          idx;
		int          steps;
		for (int r = 0; r < 16; r++) begin
			model_regs[r]  = '0;
			model_clint[r] = 1'b0;
		end
		pc = RESET_PC;
		stop = 1'b0;
		steps = 0;
		while (!stop && steps < 4 * PROG_LEN) begin
			idx = int'((pc - RESET_PC) >> 2);
			exp_reads.push_back(pc);
			nxt = pc + 32'd4;
			im  = prog_imm[idx];
			f   = prog_f3[idx];
			rd  = prog_rd[idx];
			s1  = model_regs[prog_rs1[idx]];
			s2  = model_regs[prog_rs2[idx]];
			a   = s1 + im;
			case (prog_kind[idx])
				K_OP:    write_reg(rd, alu_ref(f, prog_alt[idx], s1, s2), 1'b0);
				K_IMM:   write_reg(rd, alu_ref(f, prog_alt[idx], s1, im), 1'b0);
				K_LUI:   write_reg(rd, im, 1'b0);
				K_AUIPC: write_reg(rd, pc + im, 1'b0);
				K_BR: if (taken_ref(f, s1, s2)) nxt = pc + im;
				K_JAL: begin
					write_reg(rd, pc + 32'd4, 1'b0);
					nxt = pc + im;
				end
				K_JALR: begin
					nxt = a & ~32'd1;
					write_reg(rd, pc + 32'd4, 1'b0);
				end
				K_LOAD: begin
					if ((a & CLINT_MASK) == CLINT_BASE) begin
						write_reg(rd, '0, 1'b1);
					end else begin
						exp_reads.push_back(a & ~32'd3);
						w = read_ref(a & ~32'd3) >> {a[1:0], 3'b000};
						case (f)
							3'd0: v = {{24{w[7]}}, w[7:0]};
							3'd1: v = {{16{w[15]}}, w[15:0]};
							3'd4: v = {24'b0, w[7:0]};
							3'd5: v = {16'b0, w[15:0]};
							default: v = w;
						endcase
						write_reg(rd, v, 1'b0);
					end
				end
				default: begin
					case (f[1:0])
						2'd0: sl = 4'b0001 << a[1:0];
						2'd1: sl = 4'b0011 << a[1:0];
						default: sl = 4'b1111;
					endcase
					v = s2 << {a[1:0], 3'b000};
					exp_st_adr.push_back(a & ~32'd3);
					exp_st_sel.push_back(sl);
					exp_st_dat.push_back(v);
					exp_st_clint.push_back(model_clint[prog_rs2[idx]]);
					ref_mem[a & ~32'd3] = merge_word(read_ref(a & ~32'd3), sl, v);
					if (a == HALT_ADDR)
						stop = 1'b1;
				end
			endcase
			pc = nxt;
			steps++;
		end
		if (!stop)
			report("The reference model never reached the halt store.");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
	                     input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic report(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic serve_access();
		logic [31:0] mask;
		logic [31:0] old;
		old = mem.exists(wb_adr) ? mem[wb_adr] : fill_word(wb_adr);
		if (!halted && (wb_adr & CLINT_MASK) == CLINT_BASE)
			report("A timer access appeared on the external bus.");
		if (wb_we) begin
			mem[wb_adr] = merge_word(old, wb_sel, wb_dat_w);
			if (halted) begin
			end else if (exp_st_adr.size() == 0) begin
				report("The DUT made a store that the model does not expect.");
			end else begin
				mask = {{8{wb_sel[3]}}, {8{wb_sel[2]}}, {8{wb_sel[1]}}, {8{wb_sel[0]}}};
				check("store address", exp_st_adr.pop_front(), wb_adr);
				check("store sel", {28'b0, exp_st_sel.pop_front()}, {28'b0, wb_sel});
				if (exp_st_clint.pop_front())
					clint_vals.push_back(wb_dat_w);
				else
					check("store data", exp_st_dat[0] & mask, wb_dat_w & mask);
				void'(exp_st_dat.pop_front());
				if (wb_adr == HALT_ADDR)
					halted = 1'b1;
			end
		end else begin
			wb_dat_r = old;
			if (halted) begin
			end else if (exp_reads.size() == 0)
				report("The DUT made a read that the model does not expect.");
			else
				check("read address", exp_reads.pop_front(), wb_adr);
		end
	endtask

	// Memory answers after 0 to 3 wait states.
	always @(negedge clock) begin
		if (!rst_n) begin
			wb_ack = 1'b0;
			pending = 1'b0;
			if (wb_cyc || wb_stb)
				report("The DUT requested the bus while reset was asserted.");
		end else if (wb_ack) begin
			wb_ack = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!pending) begin
				pending = 1'b1;
				delay = 2'(rand_bits(2));
			end
			if (delay == 2'd0) begin
				serve_access();
				wb_ack = 1'b1;
				pending = 1'b0;
			end else begin
				delay = delay - 2'd1;
			end
		end
	end

	task automatic finish_run();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	initial begin
		#(TIMEOUT_CYCLES * 40);
		report("Timeout: the program did not reach the halt store.");
		finish_run();
	end

	initial begin
		rst_n = 1'b0;
		wb_ack = 1'b0;
		wb_dat_r = '0;
		build_program();
		run_model();
		repeat (5) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		wait (halted);
		repeat (2) @(posedge clock);
		if (exp_reads.size() != 0)
			report("Some expected reads never reached the external bus.");
		if (exp_st_adr.size() != 0)
			report("Some expected stores never reached the external bus.");
		if (clint_vals.size() != 2)
			report("The two timer values were not both stored out.");
		else if (clint_vals[1] <= clint_vals[0])
			report("The second timer value is not greater than the first.");
		finish_run();
	end

endmodule

`default_nettype wire

// ==== hw/bus_xbar.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_xbar (
	wb_if.slave         ifu,
	wb_if.slave         lsu,
	wb_if.master        clint,
	output logic        ext_cyc,
	output logic        ext_stb,
	output logic        ext_we,
	output logic [31:0] ext_adr,
	output logic [31:0] ext_dat_w,
	output logic [3:0]  ext_sel,
	input  logic [31:0] ext_dat_r,
	input  logic        ext_ack
);
	import core_pkg::*;

	logic        grant_ifu;
	logic        to_clint;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [31:0] adr;
	logic [31:0] dat_w;
	logic [3:0]  sel;
	logic        ack;
	logic [31:0] dat_r;

	assign grant_ifu = ifu.cyc; // Fetch wins a tie.

	assign cyc   = grant_ifu ? ifu.cyc   : lsu.cyc;
	assign stb   = grant_ifu ? ifu.stb   : lsu.stb;
	assign we    = grant_ifu ? ifu.we    : lsu.we;
	assign adr   = grant_ifu ? ifu.adr   : lsu.adr;
	assign dat_w = grant_ifu ? ifu.dat_w : lsu.dat_w;
	assign sel   = grant_ifu ? ifu.sel   : lsu.sel;

	assign to_clint = ((adr & CLINT_MASK) == CLINT_BASE);

	assign clint.cyc   = cyc & to_clint;
	assign clint.stb   = stb & to_clint;
	assign clint.we    = we;
	assign clint.adr   = adr;
	assign clint.dat_w = dat_w;
	assign clint.sel   = sel;

	assign ext_cyc   = cyc & ~to_clint;
	assign ext_stb   = stb & ~to_clint;
	assign ext_we    = we;
	assign ext_adr   = adr;
	assign ext_dat_w = dat_w;
	assign ext_sel   = sel;

	assign ack   = to_clint ? clint.ack   : ext_ack;
	assign dat_r = to_clint ? clint.dat_r : ext_dat_r;

	assign ifu.ack   = grant_ifu & ack;
	assign lsu.ack   = ~grant_ifu & ack;
	assign ifu.dat_r = grant_ifu ? dat_r : '0;
	assign lsu.dat_r = grant_ifu ? '0 : dat_r;

endmodule

`default_nettype wire

// ==== hw/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
	input logic  clock,
	input logic  rst_n,
	wb_if.slave  bus
);

	logic [63:0] mtime;
	logic        ack_q;
	logic [31:0] dat_q;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
			ack_q <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			ack_q <= bus.cyc & bus.stb & ~ack_q;
		end
	end

	// Offset 4 returns the high word; writes only get an ack.
	always_ff @(posedge clock) begin
		if (bus.cyc && bus.stb && !ack_q)
			dat_q <= bus.adr[2] ? mtime[63:32] : mtime[31:0];
	end

	assign bus.ack   = ack_q;
	assign bus.dat_r = dat_q;

endmodule

`default_nettype wire

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_IMM    = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	// Matches funct3[1:0] of loads and stores.
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2, rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2, rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2, rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_word_u;

	localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
	localparam logic [31:0] CLINT_MASK = 32'hffff_0000; // 64 KiB window.

endpackage

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter logic [31:0] RESET_PC = 32'h3000_0000,
	parameter int          NUM_REGS = 16
) (
	input  logic        clock,
	input  logic        rst_n,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output logic [31:0] wb_adr,
	output logic [31:0] wb_dat_w,
	output logic [3:0]  wb_sel,
	input  logic [31:0] wb_dat_r,
	input  logic        wb_ack
);
	import core_pkg::*;

	localparam int RW = $clog2(NUM_REGS);

	localparam logic [1:0] PH_FETCH  = 2'd0; // Also the execute cycle once inst_valid.
	localparam logic [1:0] PH_MEM    = 2'd1;
	localparam logic [1:0] PH_RETIRE = 2'd2;

	logic [1:0]    phase;
	logic          boot;
	logic          exec;
	logic          retire;
	logic          fetch_start;
	logic          mem_start;
	logic [31:0]   pc;
	logic [31:0]   next_pc;
	logic [31:0]   inst;
	logic          inst_valid;
	logic [RW-1:0] rs1;
	logic [RW-1:0] rs2;
	logic [RW-1:0] rd;
	logic [31:0]   imm;
	alu_op_e       alu_op;
	logic          use_imm;
	logic          reg_wen;
	logic          is_load;
	logic          is_store;
	logic          is_branch;
	logic          is_jal;
	logic          is_jalr;
	logic          is_auipc;
	logic          is_lui;
	mem_size_e     size;
	logic          load_unsigned;
	logic [31:0]   src1;
	logic [31:0]   src2;
	logic [31:0]   result;
	logic [31:0]   mem_addr;
	logic [31:0]   load_data;
	logic          lsu_done;
	logic [31:0]   wb_value;

	wb_if ifu_bus();
	wb_if lsu_bus();
	wb_if clint_bus();

	assign exec        = (phase == PH_FETCH) & inst_valid;
	assign mem_start   = exec & (is_load | is_store);
	assign retire      = (phase == PH_RETIRE) | ((phase == PH_MEM) & lsu_done);
	assign fetch_start = boot | retire;
	assign wb_value    = is_load ? load_data : result;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			boot  <= 1'b1;
			phase <= PH_FETCH;
			pc    <= RESET_PC;
		end else begin
			boot <= 1'b0;
			if (retire)
				pc <= next_pc;
			case (phase)
				PH_FETCH: if (exec) phase <= mem_start ? PH_MEM : PH_RETIRE;
				PH_MEM:   if (lsu_done) phase <= PH_FETCH;
				default:  phase <= PH_FETCH;
			endcase
		end
	end

	fetch_unit u_fetch (
		.clock(clock), .rst_n(rst_n), .start(fetch_start), .pc(pc),
		.bus(ifu_bus.master), .inst(inst), .inst_valid(inst_valid)
	);

	decoder #(.NUM_REGS(NUM_REGS)) u_decoder (
		.inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
		.use_imm(use_imm), .reg_wen(reg_wen), .is_load(is_load), .is_store(is_store),
		.is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .is_auipc(is_auipc),
		.is_lui(is_lui), .size(size), .load_unsigned(load_unsigned)
	);

	reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
		.clock(clock), .rst_n(rst_n), .raddr1(rs1), .raddr2(rs2), .rdata1(src1),
		.rdata2(src2), .waddr(rd), .wdata(wb_value), .wen(retire & reg_wen)
	);

	exec_unit u_exec (
		.pc(pc), .src1(src1), .src2(src2), .imm(imm), .alu_op(alu_op), .use_imm(use_imm),
		.is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .is_auipc(is_auipc),
		.is_lui(is_lui), .funct3(inst[14:12]), .result(result), .next_pc(next_pc),
		.mem_addr(mem_addr)
	);

	load_store u_lsu (
		.clock(clock), .rst_n(rst_n), .start(mem_start), .we(is_store), .addr(mem_addr),
		.store_data(src2), .size(size), .load_unsigned(load_unsigned),
		.bus(lsu_bus.master), .load_data(load_data), .done(lsu_done)
	);

	bus_xbar u_xbar (
		.ifu(ifu_bus.slave), .lsu(lsu_bus.slave), .clint(clint_bus.master),
		.ext_cyc(wb_cyc), .ext_stb(wb_stb), .ext_we(wb_we), .ext_adr(wb_adr),
		.ext_dat_w(wb_dat_w), .ext_sel(wb_sel), .ext_dat_r(wb_dat_r), .ext_ack(wb_ack)
	);

	clint_timer u_clint (
		.clock(clock), .rst_n(rst_n), .bus(clint_bus.slave)
	);

endmodule

`default_nettype wire

// ==== hw/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder #(
	parameter int NUM_REGS = 16
) (
	input  logic [31:0]                 inst,
	output logic [$clog2(NUM_REGS)-1:0] rs1,
	output logic [$clog2(NUM_REGS)-1:0] rs2,
	output logic [$clog2(NUM_REGS)-1:0] rd,
	output logic [31:0]                 imm,
	output core_pkg::alu_op_e           alu_op,
	output logic                        use_imm,
	output logic                        reg_wen,
	output logic                        is_load,
	output logic                        is_store,
	output logic                        is_branch,
	output logic                        is_jal,
	output logic                        is_jalr,
	output logic                        is_auipc,
	output logic                        is_lui,
	output core_pkg::mem_size_e         size,
	output logic                        load_unsigned
);
	import core_pkg::*;

	localparam int RW = $clog2(NUM_REGS);

	inst_word_u iw;
	logic [6:0] opcode;
	logic [2:0] funct3;

	assign iw     = inst;
	assign opcode = iw.r.opcode;
	assign funct3 = iw.r.funct3;

	assign rs1 = iw.r.rs1[RW-1:0];
	assign rs2 = iw.r.rs2[RW-1:0];
	assign rd  = iw.r.rd[RW-1:0];

	assign is_load   = (opcode == OPC_LOAD);
	assign is_store  = (opcode == OPC_STORE);
	assign is_branch = (opcode == OPC_BRANCH);
	assign is_jal    = (opcode == OPC_JAL);
	assign is_jalr   = (opcode == OPC_JALR);
	assign is_auipc  = (opcode == OPC_AUIPC);
	assign is_lui    = (opcode == OPC_LUI);
	assign use_imm   = (opcode == OPC_IMM);

	assign size          = mem_size_e'(funct3[1:0]);
	assign load_unsigned = funct3[2];

	always_comb begin
		case (opcode)
			OPC_LUI, OPC_AUIPC: imm = {iw.u.imm_31_12, 12'b0};
			OPC_JAL:
				imm = {{12{iw.j.imm_20}}, iw.j.imm_19_12, iw.j.imm_11, iw.j.imm_10_1, 1'b0};
			OPC_BRANCH:
				imm = {{20{iw.b.imm_12}}, iw.b.imm_11, iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
			OPC_STORE: imm = {{20{iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};
			default:   imm = {{20{iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
		endcase
	end

	// Bit 30 picks sub and sra; for OP-IMM only shifts look at it.
	always_comb begin
		case (funct3)
			3'b000:  alu_op = (opcode == OPC_OP && iw.r.funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001:  alu_op = ALU_SLL;
			3'b010:  alu_op = ALU_SLT;
			3'b011:  alu_op = ALU_SLTU;
			3'b100:  alu_op = ALU_XOR;
			3'b101:  alu_op = iw.r.funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110:  alu_op = ALU_OR;
			default: alu_op = ALU_AND;
		endcase
	end

	always_comb begin
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD, OPC_IMM, OPC_OP:
				reg_wen = (rd != '0);
			default: reg_wen = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  logic [31:0]       pc,
	input  logic [31:0]       src1,
	input  logic [31:0]       src2,
	input  logic [31:0]       imm,
	input  core_pkg::alu_op_e alu_op,
	input  logic              use_imm,
	input  logic              is_branch,
	input  logic              is_jal,
	input  logic              is_jalr,
	input  logic              is_auipc,
	input  logic              is_lui,
	input  logic [2:0]        funct3,
	output logic [31:0]       result,
	output logic [31:0]       next_pc,
	output logic [31:0]       mem_addr
);
	import core_pkg::*;

	logic [31:0] op_b;
	logic [31:0] alu_out;
	logic [31:0] link;
	logic [4:0]  shamt;
	logic        taken;

	assign op_b  = use_imm ? imm : src2;
	assign shamt = op_b[4:0];
	assign link  = pc + 32'd4;

	always_comb begin
		case (alu_op)
			ALU_SUB:  alu_out = src1 - op_b;
			ALU_SLL:  alu_out = src1 << shamt;
			ALU_SLT:  alu_out = {31'b0, $signed(src1) < $signed(op_b)};
			ALU_SLTU: alu_out = {31'b0, src1 < op_b};
			ALU_XOR:  alu_out = src1 ^ op_b;
			ALU_SRL:  alu_out = src1 >> shamt;
			ALU_SRA:  alu_out = $unsigned($signed(src1) >>> shamt);
			ALU_OR:   alu_out = src1 | op_b;
			ALU_AND:  alu_out = src1 & op_b;
			default:  alu_out = src1 + op_b;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  taken = (src1 == src2);
			3'b001:  taken = (src1 != src2);
			3'b100:  taken = ($signed(src1) < $signed(src2));
			3'b101:  taken = ($signed(src1) >= $signed(src2));
			3'b110:  taken = (src1 < src2);
			3'b111:  taken = (src1 >= src2);
			default: taken = 1'b0;
		endcase
	end

	assign mem_addr = src1 + imm; // Also the JALR target.

	assign result = (is_jal || is_jalr) ? link :
	                is_lui              ? imm :
	                is_auipc            ? pc + imm : alu_out;

	assign next_pc = is_jalr                        ? {mem_addr[31:1], 1'b0} :
	                 (is_jal || (is_branch && taken)) ? pc + imm : link;

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        start,
	input  logic [31:0] pc,
	wb_if.master        bus,
	output logic [31:0] inst,
	output logic        inst_valid
);

	logic busy;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= busy & bus.ack;
			if (start)
				busy <= 1'b1;
			else if (bus.ack)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (busy && bus.ack)
			inst <= bus.dat_r; // Held until the next fetch completes.
	end

	// PC only moves at retire, so the address stays stable.
	assign bus.cyc   = busy;
	assign bus.stb   = busy;
	assign bus.we    = 1'b0;
	assign bus.adr   = pc;
	assign bus.dat_w = '0;
	assign bus.sel   = 4'b1111;

endmodule

`default_nettype wire

// ==== hw/load_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                start,
	input  logic                we,
	input  logic [31:0]         addr,
	input  logic [31:0]         store_data,
	input  core_pkg::mem_size_e size,
	input  logic                load_unsigned,
	wb_if.master                bus,
	output logic [31:0]         load_data,
	output logic                done
);
	import core_pkg::*;

	logic        busy;
	logic        we_q;
	logic [31:0] adr_q;
	logic [31:0] dat_q;
	logic [3:0]  sel_q;
	logic [1:0]  off_q;
	mem_size_e   size_q;
	logic        uns_q;
	logic [3:0]  sel_c;
	logic [31:0] lane;

	always_comb begin
		case (size)
			SIZE_BYTE: sel_c = 4'b0001 << addr[1:0];
			SIZE_HALF: sel_c = 4'b0011 << {addr[1], 1'b0};
			default:   sel_c = 4'b1111;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= busy & bus.ack;
			if (start)
				busy <= 1'b1;
			else if (bus.ack)
				busy <= 1'b0;
		end
	end

	// Request is latched so it holds through any wait states.
	always_ff @(posedge clock) begin
		if (start) begin
			we_q   <= we;
			adr_q  <= {addr[31:2], 2'b00};
			dat_q  <= store_data << {addr[1:0], 3'b000};
			sel_q  <= sel_c;
			off_q  <= addr[1:0];
			size_q <= size;
			uns_q  <= load_unsigned;
		end
	end

	assign lane = bus.dat_r >> {off_q, 3'b000};

	always_ff @(posedge clock) begin
		if (busy && bus.ack) begin
			case (size_q)
				SIZE_BYTE: load_data <= {{24{~uns_q & lane[7]}}, lane[7:0]};
				SIZE_HALF: load_data <= {{16{~uns_q & lane[15]}}, lane[15:0]};
				default:   load_data <= lane;
			endcase
		end
	end

	assign bus.cyc   = busy;
	assign bus.stb   = busy;
	assign bus.we    = we_q;
	assign bus.adr   = adr_q;
	assign bus.dat_w = dat_q;
	assign bus.sel   = sel_q;

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
	parameter int NUM_REGS = 16
) (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic [$clog2(NUM_REGS)-1:0] raddr1,
	input  logic [$clog2(NUM_REGS)-1:0] raddr2,
	output logic [31:0]                 rdata1,
	output logic [31:0]                 rdata2,
	input  logic [$clog2(NUM_REGS)-1:0] waddr,
	input  logic [31:0]                 wdata,
	input  logic                        wen
);

	logic [31:0] regs [NUM_REGS];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== hw/wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [31:0] adr;
	logic [31:0] dat_w;
	logic [3:0]  sel;
	logic [31:0] dat_r;
	logic        ack;

	modport master (
		output cyc, stb, we, adr, dat_w, sel,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w, sel,
		output dat_r, ack
	);
endinterface

`default_nettype wire

// ==== src.f ====
hw/core_pkg.sv
hw/wb_if.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/load_store.sv
hw/bus_xbar.sv
hw/clint_timer.sv
hw/cpu_top.sv
bench/cpu_assertions.sv
bench/cpu_tb.sv
